/* logic/ex_consts.svh */
// --------------------------------------------------
// constants for the RV64 execute stage
// opcodes and funct codes follow the base RISC-V encodings
// funct3 codes overlap between ALU, branch and jalr use
// --------------------------------------------------
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// widths
`define EX_XLEN        64
`define EX_REG_ADDR_W  5
`define EX_IMM_W       20 // raw imm / offset field from decode
`define EX_OPCODE_W    7
`define EX_F3_W        3
`define EX_F7_W        7

// opcodes
`define EX_OP_R        7'b0110011 // add sub sll ...
`define EX_OP_IMM      7'b0010011 // addi andi slli ...
`define EX_OP_IMM_W    7'b0011011 // addiw only
`define EX_OP_R_W      7'b0111011 // addw subw sllw srlw sraw
`define EX_OP_BRANCH   7'b1100011
`define EX_OP_JAL      7'b1101111
`define EX_OP_JALR     7'b1100111
`define EX_OP_LUI      7'b0110111
`define EX_OP_AUIPC    7'b0010111

// funct3, integer ops
`define EX_F3_ADD_SUB  3'b000
`define EX_F3_SLL      3'b001
`define EX_F3_SLT      3'b010
`define EX_F3_SLTU     3'b011
`define EX_F3_XOR      3'b100
`define EX_F3_SRL_SRA  3'b101
`define EX_F3_OR       3'b110
`define EX_F3_AND      3'b111

// funct3, branches and jalr
`define EX_F3_BEQ      3'b000
`define EX_F3_BNE      3'b001
`define EX_F3_BLT      3'b100
`define EX_F3_BGE      3'b101
`define EX_F3_BLTU     3'b110
`define EX_F3_BGEU     3'b111
`define EX_F3_JALR     3'b000

`define EX_F7_BASE     7'b0000000
`define EX_F7_ALT      7'b0100000 // sub, sra, srai

`define EX_REG_ZERO    5'd0       // x0, never forwarded

`endif

/* logic/ex_pkg.sv */
// --------------------------------------------------
// shared vector types of the execute stage
// widths come from ex_consts.svh
// --------------------------------------------------
`include "ex_consts.svh"

package ex_pkg;

	// register value
	typedef logic [`EX_XLEN-1:0]       xlen_t;

	// pc or jump target, same width as a register
	typedef logic [`EX_XLEN-1:0]       addr_t;

	typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t; // x0..x31

	// decoded instruction fields
	typedef logic [`EX_OPCODE_W-1:0]   opcode_t;
	typedef logic [`EX_F3_W-1:0]       funct3_t;
	typedef logic [`EX_F7_W-1:0]       funct7_t;

	// raw immediate/offset, sign bit is bit 11 or bit 19
	typedef logic [`EX_IMM_W-1:0]      imm_t;

endpackage

/* logic/ex_operand_fwd.sv */
// --------------------------------------------------
// memory-stage bypass for rs1 and rs2
// only one forwarding source, the memory stage
// x0 always reads the register-file value
// --------------------------------------------------
`include "ex_consts.svh"

module ex_operand_fwd (
	input  logic              clk_i,              // assertion sampling only
	input  logic              arst_n_i,
	input  ex_pkg::reg_addr_t rs1_addr_i,
	input  ex_pkg::reg_addr_t rs2_addr_i,
	input  ex_pkg::xlen_t     rs1_data_i,         // from register file
	input  ex_pkg::xlen_t     rs2_data_i,
	input  ex_pkg::reg_addr_t mem_back_rd_addr_i,
	input  logic              mem_back_wreg_i,
	input  ex_pkg::xlen_t     mem_back_wdata_i,
	output ex_pkg::xlen_t     rs1_o,
	output ex_pkg::xlen_t     rs2_o
);
	logic hit_rs1; // mem stage writes rs1
	logic hit_rs2;

	assign hit_rs1 = mem_back_wreg_i && (mem_back_rd_addr_i == rs1_addr_i)
		&& (rs1_addr_i != `EX_REG_ZERO);
	assign hit_rs2 = mem_back_wreg_i && (mem_back_rd_addr_i == rs2_addr_i)
		&& (rs2_addr_i != `EX_REG_ZERO); // rs2 checks its own address

	assign rs1_o = hit_rs1 ? mem_back_wdata_i : rs1_data_i;
	assign rs2_o = hit_rs2 ? mem_back_wdata_i : rs2_data_i;

	// a stray write to x0 in the mem stage must not leak through
	a_x0_rs1_no_fwd : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(rs1_addr_i == `EX_REG_ZERO) |-> (rs1_o == rs1_data_i));
	a_x0_rs2_no_fwd : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(rs2_addr_i == `EX_REG_ZERO) |-> (rs2_o == rs2_data_i));

endmodule

/* logic/ex_alu.sv */
// --------------------------------------------------
// integer ALU of the execute stage, fully combinational
// shift amounts come from imm_i[5:0], or rs2 for register forms
// only addiw is kept of the immediate word ops
// result is zero for branches and illegal encodings
// --------------------------------------------------
`include "ex_consts.svh"

module ex_alu (
	input  ex_pkg::opcode_t opcode_i,
	input  ex_pkg::funct3_t funct3_i,
	input  ex_pkg::funct7_t funct7_i,
	input  ex_pkg::xlen_t   rs1_i,     // already forwarded
	input  ex_pkg::xlen_t   rs2_i,
	input  ex_pkg::imm_t    imm_i,
	input  ex_pkg::addr_t   pc_i,
	output ex_pkg::xlen_t   result_o,
	output logic            op_legal_o
);
	ex_pkg::xlen_t imm_i_ext;  // I immediate, sign-extended
	ex_pkg::xlen_t imm_u_ext;  // U immediate << 12, sign-extended
	logic          is_reg;     // register form, R or R_W
	ex_pkg::xlen_t op_b;       // second operand
	logic [5:0]    shamt;
	logic          alt;        // funct7 bit 5
	logic          sub;
	ex_pkg::xlen_t sra_full;
	logic          lt_s;
	logic          lt_u;
	ex_pkg::xlen_t res_full;   // 64-bit ops
	logic [31:0]   op_b_w;
	logic [31:0]   sra_w;
	logic [31:0]   res_w;      // word ops before sign extension
	ex_pkg::xlen_t res_sel;
	logic          legal;

	assign imm_i_ext = {{(`EX_XLEN-12){imm_i[11]}}, imm_i[11:0]};
	assign imm_u_ext = {{(`EX_XLEN-32){imm_i[19]}}, imm_i, 12'b0};

	assign is_reg = (opcode_i == `EX_OP_R) || (opcode_i == `EX_OP_R_W);
	assign op_b   = is_reg ? rs2_i : imm_i_ext;
	assign shamt  = is_reg ? rs2_i[5:0] : imm_i[5:0];
	assign alt    = funct7_i[5];
	assign sub    = is_reg && alt; // addi funct7 bits are immediate bits

	// kept on their own so the signed shift/compare stays signed
	assign sra_full = $signed(rs1_i) >>> shamt;
	assign lt_s     = $signed(rs1_i) < $signed(op_b);
	assign lt_u     = rs1_i < op_b;

	assign op_b_w = op_b[31:0];
	assign sra_w  = $signed(rs1_i[31:0]) >>> shamt[4:0]; // word shifts use 5 bits

	always_comb begin
		case (funct3_i)
			`EX_F3_ADD_SUB : res_full = sub ? rs1_i - op_b : rs1_i + op_b;
			`EX_F3_SLL     : res_full = rs1_i << shamt;
			`EX_F3_SLT     : res_full = ex_pkg::xlen_t'(lt_s); // 1 or 0
			`EX_F3_SLTU    : res_full = ex_pkg::xlen_t'(lt_u);
			`EX_F3_XOR     : res_full = rs1_i ^ op_b;
			`EX_F3_SRL_SRA : res_full = alt ? sra_full : rs1_i >> shamt;
			`EX_F3_OR      : res_full = rs1_i | op_b;
			default        : res_full = rs1_i & op_b; // and
		endcase
	end

	always_comb begin
		case (funct3_i)
			`EX_F3_ADD_SUB : res_w = sub ? rs1_i[31:0] - op_b_w : rs1_i[31:0] + op_b_w;
			`EX_F3_SLL     : res_w = rs1_i[31:0] << shamt[4:0];
			`EX_F3_SRL_SRA : res_w = alt ? sra_w : rs1_i[31:0] >> shamt[4:0];
			default        : res_w = '0; // illegal for word ops
		endcase
	end

	// legality of opcode/funct3/funct7
	always_comb begin
		case (opcode_i)
			`EX_OP_R : begin
				legal = (funct7_i == `EX_F7_BASE) || ((funct7_i == `EX_F7_ALT)
					&& ((funct3_i == `EX_F3_ADD_SUB) || (funct3_i == `EX_F3_SRL_SRA)));
			end
			`EX_OP_IMM : begin
				// rv64 shifts, funct7 bit 0 is shamt[5]
				case (funct3_i)
					`EX_F3_SLL     : legal = ({funct7_i[6:1], 1'b0} == `EX_F7_BASE);
					`EX_F3_SRL_SRA : legal = ({funct7_i[6:1], 1'b0} == `EX_F7_BASE)
						|| ({funct7_i[6:1], 1'b0} == `EX_F7_ALT);
					default        : legal = 1'b1;
				endcase
			end
			`EX_OP_IMM_W : legal = (funct3_i == `EX_F3_ADD_SUB); // addiw
			`EX_OP_R_W : begin
				case (funct3_i)
					`EX_F3_ADD_SUB,
					`EX_F3_SRL_SRA : legal = (funct7_i == `EX_F7_BASE)
						|| (funct7_i == `EX_F7_ALT);
					`EX_F3_SLL     : legal = (funct7_i == `EX_F7_BASE);
					default        : legal = 1'b0;
				endcase
			end
			`EX_OP_BRANCH : legal = (funct3_i != 3'b010) && (funct3_i != 3'b011);
			`EX_OP_JALR   : legal = (funct3_i == `EX_F3_JALR);
			`EX_OP_JAL,
			`EX_OP_LUI,
			`EX_OP_AUIPC  : legal = 1'b1;
			default       : legal = 1'b0;
		endcase
	end

	always_comb begin
		case (opcode_i)
			`EX_OP_R, `EX_OP_IMM     : res_sel = res_full;
			`EX_OP_R_W, `EX_OP_IMM_W : res_sel = {{(`EX_XLEN-32){res_w[31]}}, res_w};
			`EX_OP_LUI               : res_sel = imm_u_ext;
			`EX_OP_AUIPC             : res_sel = pc_i + imm_u_ext;
			`EX_OP_JAL, `EX_OP_JALR  : res_sel = pc_i + 'd4; // link value
			default                  : res_sel = '0;         // branches write nothing
		endcase
	end

	assign result_o   = legal ? res_sel : '0;
	assign op_legal_o = legal;

endmodule

/* logic/ex_branch_unit.sv */
// --------------------------------------------------
// branch condition and target, combinational
// pc_i is assumed halfword aligned, bit 0 zero
// jalr only jumps with its legal funct3
// --------------------------------------------------
`include "ex_consts.svh"

module ex_branch_unit (
	input  logic            clk_i,     // assertion sampling only
	input  logic            arst_n_i,
	input  ex_pkg::opcode_t opcode_i,
	input  ex_pkg::funct3_t funct3_i,
	input  ex_pkg::xlen_t   rs1_i,     // forwarded operands
	input  ex_pkg::xlen_t   rs2_i,
	input  ex_pkg::imm_t    offset_i,
	input  ex_pkg::addr_t   pc_i,
	output logic            taken_o,
	output ex_pkg::addr_t   target_o
);
	logic          eq;
	logic          lt_s;
	logic          lt_u;
	logic          cond;        // branch condition for funct3
	ex_pkg::addr_t off_b;       // 12-bit halfword offset, doubled
	ex_pkg::addr_t off_j;       // 20-bit halfword offset, doubled
	ex_pkg::addr_t jalr_sum;

	assign eq   = (rs1_i == rs2_i);
	assign lt_s = $signed(rs1_i) < $signed(rs2_i);
	assign lt_u = rs1_i < rs2_i;

	always_comb begin
		case (funct3_i)
			`EX_F3_BEQ  : cond = eq;
			`EX_F3_BNE  : cond = !eq;
			`EX_F3_BLT  : cond = lt_s;
			`EX_F3_BGE  : cond = !lt_s;
			`EX_F3_BLTU : cond = lt_u;
			`EX_F3_BGEU : cond = !lt_u;
			default     : cond = 1'b0; // 010/011 are not branches
		endcase
	end

	assign taken_o = ((opcode_i == `EX_OP_BRANCH) && cond)
		|| (opcode_i == `EX_OP_JAL)
		|| ((opcode_i == `EX_OP_JALR) && (funct3_i == `EX_F3_JALR));

	assign off_b    = {{(`EX_XLEN-13){offset_i[11]}}, offset_i[11:0], 1'b0};
	assign off_j    = {{(`EX_XLEN-21){offset_i[19]}}, offset_i, 1'b0};
	assign jalr_sum = rs1_i + {{(`EX_XLEN-12){offset_i[11]}}, offset_i[11:0]}; // byte offset

	always_comb begin
		case (opcode_i)
			`EX_OP_JAL  : target_o = pc_i + off_j;
			`EX_OP_JALR : target_o = {jalr_sum[`EX_XLEN-1:1], 1'b0}; // clear bit 0
			default     : target_o = pc_i + off_b;
		endcase
	end

	// holds only while the fetch side keeps pc aligned
	a_target_aligned : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		taken_o |-> (target_o[0] == 1'b0));

endmodule

/* logic/ex_stage.sv */
// --------------------------------------------------
// RV64 execute stage, one instruction per cycle
// no stall input, the consumer takes every cycle
// outputs registered one cycle after valid_i
// ex_back_* are same-cycle, for forwarding in decode
// --------------------------------------------------
`include "ex_consts.svh"

module ex_stage (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              valid_i,
	input  ex_pkg::addr_t     pc_i,
	input  ex_pkg::opcode_t   opcode_i,
	input  ex_pkg::funct3_t   funct3_i,
	input  ex_pkg::funct7_t   funct7_i,
	input  ex_pkg::reg_addr_t rs1_addr_i,
	input  ex_pkg::reg_addr_t rs2_addr_i,
	input  ex_pkg::xlen_t     rs1_data_i,
	input  ex_pkg::xlen_t     rs2_data_i,
	input  ex_pkg::reg_addr_t rd_addr_i,
	input  logic              wreg_i,             // decode wants rd written
	input  ex_pkg::imm_t      imm_i,
	input  ex_pkg::imm_t      offset_i,
	input  ex_pkg::reg_addr_t mem_back_rd_addr_i, // mem stage write-back
	input  logic              mem_back_wreg_i,
	input  ex_pkg::xlen_t     mem_back_wdata_i,
	output ex_pkg::reg_addr_t rd_addr_o,
	output logic              wreg_o,
	output ex_pkg::xlen_t     wdata_o,
	output ex_pkg::opcode_t   opcode_o,
	output ex_pkg::funct3_t   funct3_o,
	output ex_pkg::funct7_t   funct7_o,
	output logic              valid_o,
	output logic              branch_flag_o,
	output ex_pkg::addr_t     pc_new_o,
	output ex_pkg::reg_addr_t ex_back_rd_addr_o,
	output logic              ex_back_wreg_o,
	output ex_pkg::xlen_t     ex_back_wdata_o
);
	ex_pkg::xlen_t rs1_fwd;
	ex_pkg::xlen_t rs2_fwd;
	ex_pkg::xlen_t alu_result; // zero when illegal
	logic          op_legal;
	logic          br_taken;
	ex_pkg::addr_t br_target;
	logic          wr_en;      // gated write enable
	logic          br_flag;

	ex_operand_fwd u_fwd (
		.clk_i              (clk),
		.arst_n_i           (arst_n_i),
		.rs1_addr_i         (rs1_addr_i),
		.rs2_addr_i         (rs2_addr_i),
		.rs1_data_i         (rs1_data_i),
		.rs2_data_i         (rs2_data_i),
		.mem_back_rd_addr_i (mem_back_rd_addr_i),
		.mem_back_wreg_i    (mem_back_wreg_i),
		.mem_back_wdata_i   (mem_back_wdata_i),
		.rs1_o              (rs1_fwd),
		.rs2_o              (rs2_fwd)
	);

	ex_alu u_alu (
		.opcode_i   (opcode_i),
		.funct3_i   (funct3_i),
		.funct7_i   (funct7_i),
		.rs1_i      (rs1_fwd),
		.rs2_i      (rs2_fwd),
		.imm_i      (imm_i),
		.pc_i       (pc_i),
		.result_o   (alu_result),
		.op_legal_o (op_legal)
	);

	ex_branch_unit u_branch (
		.clk_i    (clk),
		.arst_n_i (arst_n_i),
		.opcode_i (opcode_i),
		.funct3_i (funct3_i),
		.rs1_i    (rs1_fwd),
		.rs2_i    (rs2_fwd),
		.offset_i (offset_i),
		.pc_i     (pc_i),
		.taken_o  (br_taken),
		.target_o (br_target)
	);

	assign wr_en   = valid_i && wreg_i && op_legal;
	assign br_flag = valid_i && br_taken;

	// same-cycle bypass
	assign ex_back_rd_addr_o = rd_addr_i;
	assign ex_back_wreg_o    = wr_en;
	assign ex_back_wdata_o   = alu_result;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o       <= 1'b0;
			wreg_o        <= 1'b0;
			branch_flag_o <= 1'b0;
			rd_addr_o     <= `EX_REG_ZERO;
			wdata_o       <= '0;
			opcode_o      <= '0;
			funct3_o      <= '0;
			funct7_o      <= '0;
			pc_new_o      <= '0;
		end else begin
			valid_o       <= valid_i;
			wreg_o        <= wr_en;
			branch_flag_o <= br_flag;
			rd_addr_o     <= op_legal ? rd_addr_i : `EX_REG_ZERO; // illegal drops rd
			wdata_o       <= alu_result;
			opcode_o      <= opcode_i;  // pass-through for mem stage
			funct3_o      <= funct3_i;
			funct7_o      <= funct7_i;
			pc_new_o      <= br_flag ? br_target : '0;
		end
	end

	// a redirect must come with a valid instruction
	a_branch_valid : assert property (@(posedge clk) disable iff (!arst_n_i)
		branch_flag_o |-> valid_o);

endmodule

/* tb/tb_clk_gen.sv */
// --------------------------------------------------
// free-running clock and power-on reset
// reset is released on a falling edge
// --------------------------------------------------
module tb_clk_gen #(
	parameter int period_ns    = 20,
	parameter int reset_cycles = 8
) (
	output logic clk_o,
	output logic arst_n_o
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_o = 1'b0;
		forever #(period_ns / 2) clk_o = ~clk_o;
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (reset_cycles) @(posedge clk_o);
		@(negedge clk_o); // away from the rising edge
		arst_n_o = 1'b1;
	end

endmodule

/* tb/tb_ex_stage.sv */
// --------------------------------------------------
// random testbench for the RV64 execute stage
// xorshift stimulus with seed 48, one instruction per cycle
// inputs change on the falling edge, registered outputs checked there
// pc kept word aligned, branches drive wreg_i low like decode does
// --------------------------------------------------
`include "ex_consts.svh"

module tb_ex_stage;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_alu        = 400;
	localparam int n_fwd        = 300;
	localparam int n_branch     = 300;
	localparam int n_upper      = 100;
	localparam int n_illegal    = 150;
	localparam int n_mix        = 400;
	localparam int reset_cycles = 8;
	localparam int cycle_limit  = n_alu + n_fwd + n_branch + n_upper + n_illegal + n_mix
		+ reset_cycles + 20;

	// mix draws from the first four stimulus kinds
	localparam int k_alu     = 0;
	localparam int k_branch  = 1;
	localparam int k_upper   = 2;
	localparam int k_illegal = 3;
	localparam int k_fwd     = 4;
	localparam int k_mix     = 5;

	logic              clk;
	logic              arst_n_i;
	logic              valid_i, wreg_i, mem_back_wreg_i;
	logic              valid_o, wreg_o, branch_flag_o, ex_back_wreg_o;
	ex_pkg::addr_t     pc_i, pc_new_o;
	ex_pkg::opcode_t   opcode_i, opcode_o;
	ex_pkg::funct3_t   funct3_i, funct3_o;
	ex_pkg::funct7_t   funct7_i, funct7_o;
	ex_pkg::reg_addr_t rs1_addr_i, rs2_addr_i, rd_addr_i, mem_back_rd_addr_i;
	ex_pkg::reg_addr_t rd_addr_o, ex_back_rd_addr_o;
	ex_pkg::xlen_t     rs1_data_i, rs2_data_i, mem_back_wdata_i;
	ex_pkg::xlen_t     wdata_o, ex_back_wdata_o;
	ex_pkg::imm_t      imm_i, offset_i;

	typedef struct packed {
		logic              valid;
		logic              wreg;
		logic              branch;
		ex_pkg::reg_addr_t rd;
		ex_pkg::xlen_t     wdata;
		ex_pkg::addr_t     pc_new;
		ex_pkg::opcode_t   opcode;
		ex_pkg::funct3_t   funct3;
		ex_pkg::funct7_t   funct7;
	} expect_t;

	expect_t     exp_q[$];         // one entry per driven cycle
	logic [63:0] rng_state = 64'd48;
	int          errors    = 0;
	int          n_checks  = 0;
	int          n_tests   = 0;
	int          cycle_cnt = 0;

	tb_clk_gen #(.period_ns(20), .reset_cycles(reset_cycles)) u_clk (
		.clk_o    (clk),
		.arst_n_o (arst_n_i)
	);

	ex_stage u_dut (.*);

	function automatic logic [63:0] next_rand();
		logic [63:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 7);
		s = s ^ (s << 17);
		rng_state = s;
		return s;
	endfunction

	// sign-extend the low bits of v
	function automatic ex_pkg::xlen_t sext(input logic [63:0] v, input int unsigned bits);
		logic signed [63:0] t;
		t = v << (64 - bits);
		return t >>> (64 - bits);
	endfunction

	function automatic ex_pkg::xlen_t forwarded(input ex_pkg::reg_addr_t addr,
			input ex_pkg::xlen_t rf_val);
		if (mem_back_wreg_i && (addr != 5'd0) && (addr == mem_back_rd_addr_i))
			return mem_back_wdata_i;
		return rf_val; // x0 or no hit
	endfunction

	function automatic logic legal_encoding(input ex_pkg::opcode_t op,
			input ex_pkg::funct3_t f3, input ex_pkg::funct7_t f7);
		logic base;
		logic alt;
		logic addsub_sr;
		base      = (f7 == `EX_F7_BASE);
		alt       = (f7 == `EX_F7_ALT);
		addsub_sr = (f3 == `EX_F3_ADD_SUB) || (f3 == `EX_F3_SRL_SRA);
		case (op)
			`EX_OP_R      : return base || (alt && addsub_sr);
			`EX_OP_IMM : begin
				if (f3 == `EX_F3_SLL)
					return f7[6:1] == 6'd0; // f7[0] is shamt bit 5
				if (f3 == `EX_F3_SRL_SRA)
					return (f7[6:1] == 6'd0) || (f7[6:1] == 6'b010000);
				return 1'b1;
			end
			`EX_OP_IMM_W  : return f3 == `EX_F3_ADD_SUB;
			`EX_OP_R_W    : return ((base || alt) && addsub_sr) || (base && f3 == `EX_F3_SLL);
			`EX_OP_BRANCH : return f3[2:1] != 2'b01;
			`EX_OP_JALR   : return f3 == `EX_F3_JALR;
			`EX_OP_JAL, `EX_OP_LUI, `EX_OP_AUIPC : return 1'b1;
			default       : return 1'b0;
		endcase
	endfunction

	function automatic ex_pkg::xlen_t expected_result(input ex_pkg::opcode_t op,
			input ex_pkg::funct3_t f3, input ex_pkg::funct7_t f7, input ex_pkg::xlen_t a,
			input ex_pkg::xlen_t b, input ex_pkg::imm_t imm, input ex_pkg::addr_t pc);
		ex_pkg::xlen_t      y;  // second operand
		logic [5:0]         sh;
		logic [31:0]        w;
		logic signed [63:0] sa;
		logic signed [31:0] sw;
		logic               is_sub;
		if ((op == `EX_OP_IMM) || (op == `EX_OP_IMM_W)) begin
			y  = sext(imm, 12);
			sh = imm[5:0];
		end else begin
			y  = b;
			sh = b[5:0];
		end
		sa     = a;
		sw     = a[31:0];
		is_sub = ((op == `EX_OP_R) || (op == `EX_OP_R_W)) && f7[5];
		case (op)
			`EX_OP_R, `EX_OP_IMM : begin
				case (f3)
					`EX_F3_ADD_SUB : return is_sub ? a - y : a + y;
					`EX_F3_SLL     : return a << sh;
					`EX_F3_SLT     : return {63'd0, $signed(a) < $signed(y)};
					`EX_F3_SLTU    : return {63'd0, a < y};
					`EX_F3_XOR     : return a ^ y;
					`EX_F3_OR      : return a | y;
					`EX_F3_AND     : return a & y;
					default : begin
						if (f7[5])
							return sa >>> sh;
						return a >> sh;
					end
				endcase
			end
			`EX_OP_R_W, `EX_OP_IMM_W : begin
				case (f3)
					`EX_F3_ADD_SUB : w = is_sub ? a[31:0] - y[31:0] : a[31:0] + y[31:0];
					`EX_F3_SLL     : w = a[31:0] << sh[4:0];
					`EX_F3_SRL_SRA : begin
						if (f7[5])
							w = sw >>> sh[4:0];
						else
							w = a[31:0] >> sh[4:0];
					end
					default        : w = '0;
				endcase
				return sext(w, 32);
			end
			`EX_OP_LUI              : return sext({imm, 12'd0}, 32);
			`EX_OP_AUIPC            : return pc + sext({imm, 12'd0}, 32);
			`EX_OP_JAL, `EX_OP_JALR : return pc + 64'd4; // link
			default                 : return '0;         // branches
		endcase
	endfunction

	function automatic logic branch_taken(input ex_pkg::opcode_t op, input ex_pkg::funct3_t f3,
			input ex_pkg::xlen_t a, input ex_pkg::xlen_t b);
		logic lt;
		logic ltu;
		lt  = $signed(a) < $signed(b);
		ltu = a < b;
		if (op == `EX_OP_JAL)
			return 1'b1;
		if (op == `EX_OP_JALR)
			return f3 == `EX_F3_JALR;
		if (op != `EX_OP_BRANCH)
			return 1'b0;
		case (f3)
			`EX_F3_BEQ  : return a == b;
			`EX_F3_BNE  : return a != b;
			`EX_F3_BLT  : return lt;
			`EX_F3_BGE  : return !lt;
			`EX_F3_BLTU : return ltu;
			`EX_F3_BGEU : return !ltu;
			default     : return 1'b0;
		endcase
	endfunction

	function automatic ex_pkg::addr_t branch_target(input ex_pkg::opcode_t op,
			input ex_pkg::xlen_t a, input ex_pkg::imm_t off, input ex_pkg::addr_t pc);
		if (op == `EX_OP_JAL)
			return pc + (sext(off, 20) << 1);  // halfwords
		if (op == `EX_OP_JALR)
			return (a + sext(off, 12)) & ~64'd1; // byte offset with bit 0 cleared
		return pc + (sext(off, 12) << 1);
	endfunction

	task automatic mismatch(input string msg);
		errors++;
		$display("MISMATCH %0t: %s", $time, msg);
	endtask

	task automatic check_xlen(input ex_pkg::xlen_t got, input ex_pkg::xlen_t exp, input string what);
		n_checks++;
		if (got !== exp)
			mismatch($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_addr(input ex_pkg::addr_t got, input ex_pkg::addr_t exp, input string what);
		n_checks++;
		if (got !== exp)
			mismatch($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_reg_addr(input ex_pkg::reg_addr_t got, input ex_pkg::reg_addr_t exp,
			input string what);
		n_checks++;
		if (got !== exp)
			mismatch($sformatf("%s got x%0d expected x%0d", what, got, exp));
	endtask

	task automatic check_opcode(input ex_pkg::opcode_t got, input ex_pkg::opcode_t exp,
			input string what);
		n_checks++;
		if (got !== exp)
			mismatch($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic check_funct3(input ex_pkg::funct3_t got, input ex_pkg::funct3_t exp,
			input string what);
		n_checks++;
		if (got !== exp)
			mismatch($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic check_funct7(input ex_pkg::funct7_t got, input ex_pkg::funct7_t exp,
			input string what);
		n_checks++;
		if (got !== exp)
			mismatch($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		n_checks++;
		if (got !== exp)
			mismatch($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic check_registered(input expect_t e);
		check_bit(valid_o, e.valid, "valid_o");
		check_bit(wreg_o, e.wreg, "wreg_o");
		check_bit(branch_flag_o, e.branch, "branch_flag_o");
		check_reg_addr(rd_addr_o, e.rd, "rd_addr_o");
		check_xlen(wdata_o, e.wdata, "wdata_o");
		check_addr(pc_new_o, e.pc_new, "pc_new_o");
		check_opcode(opcode_o, e.opcode, "opcode_o");
		check_funct3(funct3_o, e.funct3, "funct3_o");
		check_funct7(funct7_o, e.funct7, "funct7_o");
	endtask

	task automatic make_stimulus(input int kind);
		logic [63:0] r; // fields
		logic [63:0] c; // opcode choice
		int          k;
		r                  = next_rand();
		c                  = next_rand();
		k                  = (kind == k_mix) ? int'(c[9:8]) : kind;
		valid_i            = (r[2:0] != 3'd0); // about 1 in 8 idle
		pc_i               = next_rand() & ~64'd3;
		rs1_addr_i         = {2'b00, r[5:3]};  // x0..x7 so hits are frequent
		rs2_addr_i         = {2'b00, r[8:6]};
		rd_addr_i          = r[13:9];
		funct3_i           = r[16:14];
		funct7_i           = r[17] ? `EX_F7_ALT : `EX_F7_BASE;
		imm_i              = r[37:18];
		offset_i           = r[57:38];
		rs1_data_i         = next_rand();
		rs2_data_i         = r[58] ? rs1_data_i : next_rand(); // equal operands for beq
		mem_back_wreg_i    = r[59] || ((kind == k_fwd) && r[60]);
		mem_back_rd_addr_i = r[61] ? rs1_addr_i : rs2_addr_i;
		mem_back_wdata_i   = next_rand();
		if (c[7:4] == 4'd0)
			funct7_i = c[16:10]; // odd funct7
		case (k)
			k_branch : begin
				case (c[1:0])
					2'd2    : opcode_i = `EX_OP_JAL;
					2'd3    : opcode_i = `EX_OP_JALR;
					default : opcode_i = `EX_OP_BRANCH;
				endcase
				if ((opcode_i == `EX_OP_JALR) && (c[3:2] != 2'd0))
					funct3_i = `EX_F3_JALR;
			end
			k_upper   : opcode_i = c[0] ? `EX_OP_LUI : `EX_OP_AUIPC;
			k_illegal : opcode_i = c[22:16]; // mostly undefined opcodes
			default : begin
				case (c[1:0])
					2'd0    : opcode_i = `EX_OP_R;
					2'd1    : opcode_i = `EX_OP_IMM;
					2'd2    : opcode_i = `EX_OP_R_W;
					default : opcode_i = `EX_OP_IMM_W;
				endcase
			end
		endcase
		wreg_i = (opcode_i != `EX_OP_BRANCH) && (c[63:61] != 3'd0);
	endtask

	// check last cycle's registered outputs, drive a new instruction, check ex_back_*
	task automatic run_cycle(input int kind);
		expect_t       e;
		ex_pkg::xlen_t a;
		ex_pkg::xlen_t b;
		logic          legal;
		logic          taken;
		@(negedge clk);
		if (exp_q.size() > 0)
			check_registered(exp_q.pop_front());
		make_stimulus(kind);
		a        = forwarded(rs1_addr_i, rs1_data_i);
		b        = forwarded(rs2_addr_i, rs2_data_i);
		legal    = legal_encoding(opcode_i, funct3_i, funct7_i);
		taken    = valid_i && branch_taken(opcode_i, funct3_i, a, b);
		e.valid  = valid_i;
		e.wreg   = valid_i && wreg_i && legal;
		e.branch = taken;
		e.rd     = legal ? rd_addr_i : 5'd0;
		e.wdata  = legal ? expected_result(opcode_i, funct3_i, funct7_i, a, b, imm_i, pc_i) : '0;
		e.pc_new = taken ? branch_target(opcode_i, a, offset_i, pc_i) : '0;
		e.opcode = opcode_i;
		e.funct3 = funct3_i;
		e.funct7 = funct7_i;
		exp_q.push_back(e);
		#1;
		check_reg_addr(ex_back_rd_addr_o, rd_addr_i, "ex_back_rd_addr_o");
		check_bit(ex_back_wreg_o, e.wreg, "ex_back_wreg_o");
		check_xlen(ex_back_wdata_o, e.wdata, "ex_back_wdata_o");
	endtask

	task automatic run_test(input string name, input int kind, input int n);
		int err_start;
		err_start = errors;
		repeat (n) run_cycle(kind);
		n_tests++;
		$display("%-8s %4d cycles, %0d errors", name, n, errors - err_start);
	endtask

	initial begin
		{valid_i, pc_i, opcode_i, funct3_i, funct7_i, rs1_addr_i, rs2_addr_i, rs1_data_i,
			rs2_data_i, rd_addr_i, wreg_i, imm_i, offset_i, mem_back_rd_addr_i,
			mem_back_wreg_i, mem_back_wdata_i} = '0;
		wait (arst_n_i === 1'b1);
		check_registered('0); // reset values before any clock edge
		n_tests++;
		$display("%-8s %4d cycles, %0d errors", "reset", 1, errors);
		run_test("alu", k_alu, n_alu);
		run_test("forward", k_fwd, n_fwd);
		run_test("branch", k_branch, n_branch);
		run_test("upper", k_upper, n_upper);
		run_test("illegal", k_illegal, n_illegal);
		run_test("mix", k_mix, n_mix);
		@(negedge clk);
		check_registered(exp_q.pop_front()); // last instruction
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// watchdog
	initial begin
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run did not end within %0d cycles", cycle_limit);
		$display("test failed");
		$finish;
	end

endmodule

/* ex_stage.f */
+incdir+logic
logic/ex_pkg.sv
logic/ex_operand_fwd.sv
logic/ex_alu.sv
logic/ex_branch_unit.sv
logic/ex_stage.sv
tb/tb_clk_gen.sv
tb/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/ex_pkg.sv
      - logic/ex_operand_fwd.sv
      - logic/ex_alu.sv
      - logic/ex_branch_unit.sv
      - logic/ex_stage.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_ex_stage.sv
